// File: common/exe_settings.svh
`ifndef EXE_SETTINGS_SVH
`define EXE_SETTINGS_SVH

// integer datapath width
`define EXE_DATA_W 32

// free-running cycle counter read by rdcntvl.w / rdcntvh.w
`define EXE_CNT_W 64

// data RAM depth in 32-bit words
`define EXE_RAM_WORDS 256

`endif

// File: common/exe_ops_pkg.sv
package exe_ops_pkg;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_and  = 4'd4,
        alu_or   = 4'd5,
        alu_xor  = 4'd6,
        alu_nor  = 4'd7,
        alu_sll  = 4'd8,
        alu_srl  = 4'd9,
        alu_sra  = 4'd10,
        alu_lui  = 4'd11
    } alu_op_t;

    // loads first, then stores
    typedef enum logic [3:0] {
        mem_none  = 4'd0,
        mem_ld_b  = 4'd1,
        mem_ld_h  = 4'd2,
        mem_ld_w  = 4'd3,
        mem_ld_bu = 4'd4,
        mem_ld_hu = 4'd5,
        mem_st_b  = 4'd6,
        mem_st_h  = 4'd7,
        mem_st_w  = 4'd8
    } mem_op_t;

    // signedness travels as a separate bit
    typedef enum logic [1:0] {
        div_none = 2'd0,
        div_div  = 2'd1,
        div_mod  = 2'd2
    } div_op_t;

    typedef enum logic [2:0] {
        res_alu    = 3'd0,
        res_div    = 3'd1,
        res_mem    = 3'd2,
        res_cnt_lo = 3'd3,
        res_cnt_hi = 3'd4
    } res_src_t;

    // ine comes from decode, ale is raised in execute
    typedef enum logic [1:0] {
        excp_none = 2'd0,
        excp_ine  = 2'd1,
        excp_ale  = 2'd2
    } excp_t;

endpackage

// File: common/exe_bus_pkg.sv
`include "exe_settings.svh"

package exe_bus_pkg;

    // one decoded instruction from decode
    typedef struct packed {
        logic [`EXE_DATA_W-1:0] pc;
        logic [`EXE_DATA_W-1:0] rj_value;
        logic [`EXE_DATA_W-1:0] rkd_value;
        logic [`EXE_DATA_W-1:0] imm;
        logic                   src1_is_pc;
        logic                   src2_is_imm;
        logic                   src2_is_4;
        exe_ops_pkg::alu_op_t   alu_op;
        exe_ops_pkg::mem_op_t   mem_op;
        exe_ops_pkg::div_op_t   div_op;
        logic                   div_signed;
        exe_ops_pkg::res_src_t  res_src;
        logic [4:0]             dest;
        logic                   gr_we;
        exe_ops_pkg::excp_t     ds_excp;
    } ds_to_es_t;

    // offset is the byte address within the word, needed for load extension
    typedef struct packed {
        logic [`EXE_DATA_W-1:0] pc;
        exe_ops_pkg::mem_op_t   mem_op;
        exe_ops_pkg::res_src_t  res_src;
        logic [4:0]             dest;
        logic                   gr_we;
        logic [1:0]             offset;
        logic [`EXE_DATA_W-1:0] result;
        exe_ops_pkg::excp_t     excp;
    } es_to_ms_t;

    typedef struct packed {
        logic [`EXE_DATA_W-1:0] pc;
        logic [4:0]             dest;
        logic                   gr_we;
        logic [`EXE_DATA_W-1:0] result;
        exe_ops_pkg::excp_t     excp;
    } wb_t;

endpackage

// File: exe/alu.sv
`timescale 1ns/1ps
`include "exe_settings.svh"

module alu (
    input  exe_ops_pkg::alu_op_t   alu_op,
    input  logic [`EXE_DATA_W-1:0] src1,
    input  logic [`EXE_DATA_W-1:0] src2,
    output logic [`EXE_DATA_W-1:0] result
);

    logic [4:0] sa;

    // shift amount comes from the low five bits only
    assign sa = src2[4:0];

    always_comb begin
        case (alu_op)
            exe_ops_pkg::alu_add: begin
                result = src1 + src2;
            end
            exe_ops_pkg::alu_sub: begin
                result = src1 - src2;
            end
            exe_ops_pkg::alu_slt: begin
                result = {{(`EXE_DATA_W-1){1'b0}}, $signed(src1) < $signed(src2)};
            end
            exe_ops_pkg::alu_sltu: begin
                result = {{(`EXE_DATA_W-1){1'b0}}, src1 < src2};
            end
            exe_ops_pkg::alu_and: begin
                result = src1 & src2;
            end
            exe_ops_pkg::alu_or: begin
                result = src1 | src2;
            end
            exe_ops_pkg::alu_xor: begin
                result = src1 ^ src2;
            end
            exe_ops_pkg::alu_nor: begin
                result = ~(src1 | src2);
            end
            exe_ops_pkg::alu_sll: begin
                result = src1 << sa;
            end
            exe_ops_pkg::alu_srl: begin
                result = src1 >> sa;
            end
            exe_ops_pkg::alu_sra: begin
                result = $signed(src1) >>> sa;
            end
            // decode has already placed the upper immediate in src2
            exe_ops_pkg::alu_lui: begin
                result = src2;
            end
            default: begin
                result = src1 + src2;
            end
        endcase
    end

endmodule

// File: exe/exe_stage.sv
`timescale 1ns/1ps
`include "exe_settings.svh"

module exe_stage (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                in_valid,
    input  exe_bus_pkg::ds_to_es_t              in_bus,
    output logic                                in_allowin,
    input  logic                                ms_allowin,
    output logic                                es_to_ms_valid,
    output exe_bus_pkg::es_to_ms_t              es_to_ms_bus,
    output logic                                div_start,
    output logic                                div_signed,
    output logic [`EXE_DATA_W-1:0]              div_dividend,
    output logic [`EXE_DATA_W-1:0]              div_divisor,
    input  logic                                div_complete,
    input  logic [`EXE_DATA_W-1:0]              div_quotient,
    input  logic [`EXE_DATA_W-1:0]              div_remainder,
    output logic                                ram_en,
    output logic [3:0]                          ram_we,
    output logic [$clog2(`EXE_RAM_WORDS)-1:0]   ram_addr,
    output logic [`EXE_DATA_W-1:0]              ram_wdata
);

    localparam int aw = $clog2(`EXE_RAM_WORDS);

    logic                   es_valid;
    exe_bus_pkg::ds_to_es_t es_bus;
    logic                   ready_go;
    logic                   es_go;
    logic                   is_div;
    logic                   div_issued;
    logic [`EXE_CNT_W-1:0]  counter;
    logic [`EXE_DATA_W-1:0] alu_src1;
    logic [`EXE_DATA_W-1:0] alu_src2;
    logic [`EXE_DATA_W-1:0] alu_result;
    logic [`EXE_DATA_W-1:0] result;
    logic                   is_mem;
    logic                   is_store;
    logic                   is_half;
    logic                   is_word;
    logic                   ale;
    exe_ops_pkg::excp_t     excp;
    logic [3:0]             strobe;

    // a divide holds the stage until its own result is back
    assign is_div         = es_valid && es_bus.div_op != exe_ops_pkg::div_none;
    assign ready_go       = !is_div || (div_issued && div_complete);
    assign in_allowin     = !es_valid || (ready_go && ms_allowin);
    assign es_to_ms_valid = es_valid && ready_go;
    assign es_go          = es_to_ms_valid && ms_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (in_allowin) begin
            es_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            es_bus <= in_bus;
        end
    end

    // div_complete from an older divide may still be high, so track our own start
    always_ff @(posedge clk) begin
        if (reset) begin
            div_issued <= 1'b0;
        end else if (es_go) begin
            div_issued <= 1'b0;
        end else if (div_start) begin
            div_issued <= 1'b1;
        end
    end

    assign div_start    = is_div && !div_issued;
    assign div_signed   = es_bus.div_signed;
    assign div_dividend = es_bus.rj_value;
    assign div_divisor  = es_bus.rkd_value;

    always_ff @(posedge clk) begin
        if (reset) begin
            counter <= '0;
        end else begin
            counter <= counter + 1'b1;
        end
    end

    assign alu_src1 = es_bus.src1_is_pc ? es_bus.pc : es_bus.rj_value;
    assign alu_src2 = es_bus.src2_is_4   ? `EXE_DATA_W'd4 :
                      es_bus.src2_is_imm ? es_bus.imm     : es_bus.rkd_value;

    alu u_alu (
        .alu_op (es_bus.alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    // memory results are filled in by the memory stage
    always_comb begin
        case (es_bus.res_src)
            exe_ops_pkg::res_div: begin
                result = (es_bus.div_op == exe_ops_pkg::div_mod) ? div_remainder : div_quotient;
            end
            exe_ops_pkg::res_cnt_lo: begin
                result = counter[`EXE_DATA_W-1:0];
            end
            exe_ops_pkg::res_cnt_hi: begin
                result = counter[`EXE_CNT_W-1:`EXE_CNT_W-`EXE_DATA_W];
            end
            default: begin
                result = alu_result;
            end
        endcase
    end

    assign is_mem   = es_bus.mem_op != exe_ops_pkg::mem_none;
    assign is_store = es_bus.mem_op inside {exe_ops_pkg::mem_st_b, exe_ops_pkg::mem_st_h,
                                            exe_ops_pkg::mem_st_w};
    assign is_half  = es_bus.mem_op inside {exe_ops_pkg::mem_ld_h, exe_ops_pkg::mem_ld_hu,
                                            exe_ops_pkg::mem_st_h};
    assign is_word  = es_bus.mem_op inside {exe_ops_pkg::mem_ld_w, exe_ops_pkg::mem_st_w};
    assign ale      = (is_half && alu_result[0]) || (is_word && alu_result[1:0] != 2'b00);

    // an exception carried from decode wins over alignment
    assign excp = (es_bus.ds_excp != exe_ops_pkg::excp_none) ? es_bus.ds_excp :
                  ale ? exe_ops_pkg::excp_ale : exe_ops_pkg::excp_none;

    always_comb begin
        case (es_bus.mem_op)
            exe_ops_pkg::mem_st_b: begin
                strobe    = 4'b0001 << alu_result[1:0];
                ram_wdata = {4{es_bus.rkd_value[7:0]}};
            end
            exe_ops_pkg::mem_st_h: begin
                strobe    = 4'b0011 << {alu_result[1], 1'b0};
                ram_wdata = {2{es_bus.rkd_value[15:0]}};
            end
            default: begin
                strobe    = 4'b1111;
                ram_wdata = es_bus.rkd_value;
            end
        endcase
    end

    // request only on the move into the memory stage, so held read data stays valid
    assign ram_en   = es_go && is_mem;
    assign ram_we   = (ram_en && is_store && excp == exe_ops_pkg::excp_none) ? strobe : 4'h0;
    assign ram_addr = alu_result[2 +: aw];

    always_comb begin
        es_to_ms_bus.pc      = es_bus.pc;
        es_to_ms_bus.mem_op  = es_bus.mem_op;
        es_to_ms_bus.res_src = es_bus.res_src;
        es_to_ms_bus.dest    = es_bus.dest;
        es_to_ms_bus.gr_we   = es_bus.gr_we;
        es_to_ms_bus.offset  = alu_result[1:0];
        es_to_ms_bus.result  = result;
        es_to_ms_bus.excp    = excp;
    end

    // an offer blocked by the memory stage stays up for the same instruction
    hold_when_blocked: assert property (@(posedge clk) disable iff (reset)
        es_to_ms_valid && !ms_allowin |=> es_to_ms_valid && $stable(es_to_ms_bus.pc));

endmodule

// File: hdl/divider.sv
`timescale 1ns/1ps
`include "exe_settings.svh"

module divider (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  logic                   signed_op,
    input  logic [`EXE_DATA_W-1:0] dividend,
    input  logic [`EXE_DATA_W-1:0] divisor,
    output logic                   complete,
    output logic [`EXE_DATA_W-1:0] quotient,
    output logic [`EXE_DATA_W-1:0] remainder
);

    localparam int dw = `EXE_DATA_W;

    logic          busy;
    logic [5:0]    step;
    logic [dw-1:0] rem_r;
    logic [dw-1:0] quo_r;
    logic [dw-1:0] dvs_r;
    logic          q_neg;
    logic          r_neg;
    logic          a_neg;
    logic          b_neg;
    logic [dw:0]   partial;
    logic [dw:0]   diff;
    logic          fits;

    assign a_neg = signed_op && dividend[dw-1];
    assign b_neg = signed_op && divisor[dw-1];

    // restoring step, next dividend bit shifts in from the top of quo_r
    assign partial = {rem_r, quo_r[dw-1]};
    assign diff    = partial - {1'b0, dvs_r};
    assign fits    = partial >= {1'b0, dvs_r};

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            complete <= 1'b0;
            step     <= '0;
        end else if (start) begin
            busy     <= 1'b1;
            complete <= 1'b0;
            step     <= '0;
        end else if (busy) begin
            if (step == 6'd32) begin
                busy     <= 1'b0;
                complete <= 1'b1;
            end
            step <= step + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rem_r <= '0;
            quo_r <= a_neg ? -dividend : dividend;
            dvs_r <= b_neg ? -divisor : divisor;
            // by zero the magnitudes already give all ones and the dividend
            q_neg <= (a_neg ^ b_neg) && divisor != '0;
            r_neg <= a_neg;
        end else if (busy) begin
            if (step != 6'd32) begin
                rem_r <= fits ? diff[dw-1:0] : partial[dw-1:0];
                quo_r <= {quo_r[dw-2:0], fits};
            end else begin
                quotient  <= q_neg ? -quo_r : quo_r;
                remainder <= r_neg ? -rem_r : rem_r;
            end
        end
    end

    no_restart_while_busy: assert property (@(posedge clk) disable iff (reset)
        busy |-> !start);

endmodule

// File: hdl/mem_stage.sv
`timescale 1ns/1ps
`include "exe_settings.svh"

module mem_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   es_to_ms_valid,
    input  exe_bus_pkg::es_to_ms_t es_to_ms_bus,
    output logic                   ms_allowin,
    input  logic [`EXE_DATA_W-1:0] ram_rdata,
    output logic                   wb_valid,
    output exe_bus_pkg::wb_t       wb_bus,
    input  logic                   wb_ready
);

    logic                   ms_valid;
    exe_bus_pkg::es_to_ms_t ms_bus;
    logic [7:0]             ld_byte;
    logic [15:0]            ld_half;
    logic [`EXE_DATA_W-1:0] ld_data;

    // always ready to go once valid
    assign ms_allowin = !ms_valid || wb_ready;
    assign wb_valid   = ms_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_to_ms_valid && ms_allowin) begin
            ms_bus <= es_to_ms_bus;
        end
    end

    assign ld_byte = ram_rdata[{ms_bus.offset, 3'b000} +: 8];
    assign ld_half = ram_rdata[{ms_bus.offset[1], 4'b0000} +: 16];

    always_comb begin
        case (ms_bus.mem_op)
            exe_ops_pkg::mem_ld_b:  ld_data = {{24{ld_byte[7]}}, ld_byte};
            exe_ops_pkg::mem_ld_bu: ld_data = {24'h0, ld_byte};
            exe_ops_pkg::mem_ld_h:  ld_data = {{16{ld_half[15]}}, ld_half};
            exe_ops_pkg::mem_ld_hu: ld_data = {16'h0, ld_half};
            default:                ld_data = ram_rdata;
        endcase
    end

    always_comb begin
        wb_bus.pc     = ms_bus.pc;
        wb_bus.dest   = ms_bus.dest;
        // a faulting instruction must not reach the register file
        wb_bus.gr_we  = ms_bus.gr_we && ms_bus.excp == exe_ops_pkg::excp_none;
        wb_bus.result = (ms_bus.res_src == exe_ops_pkg::res_mem) ? ld_data : ms_bus.result;
        wb_bus.excp   = ms_bus.excp;
    end

endmodule

// File: hdl/data_ram.sv
`timescale 1ns/1ps
`include "exe_settings.svh"

module data_ram (
    input  logic                              clk,
    input  logic                              en,
    input  logic [3:0]                        we,
    input  logic [$clog2(`EXE_RAM_WORDS)-1:0] addr,
    input  logic [`EXE_DATA_W-1:0]            wdata,
    output logic [`EXE_DATA_W-1:0]            rdata
);

    logic [`EXE_DATA_W-1:0] mem [0:`EXE_RAM_WORDS-1];

    // read-first, rdata holds while en is low
    always_ff @(posedge clk) begin
        if (en) begin
            for (int b = 0; b < 4; b++) begin
                if (we[b]) begin
                    mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
            rdata <= mem[addr];
        end
    end

endmodule

// File: hdl/exe_top.sv
`timescale 1ns/1ps
`include "exe_settings.svh"

module exe_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    input  exe_bus_pkg::ds_to_es_t in_bus,
    output logic                   in_allowin,
    output logic                   wb_valid,
    output exe_bus_pkg::wb_t       wb_bus,
    input  logic                   wb_ready
);

    logic                              ms_allowin;
    logic                              es_to_ms_valid;
    exe_bus_pkg::es_to_ms_t            es_to_ms_bus;
    logic                              div_start;
    logic                              div_signed;
    logic [`EXE_DATA_W-1:0]            div_dividend;
    logic [`EXE_DATA_W-1:0]            div_divisor;
    logic                              div_complete;
    logic [`EXE_DATA_W-1:0]            div_quotient;
    logic [`EXE_DATA_W-1:0]            div_remainder;
    logic                              ram_en;
    logic [3:0]                        ram_we;
    logic [$clog2(`EXE_RAM_WORDS)-1:0] ram_addr;
    logic [`EXE_DATA_W-1:0]            ram_wdata;
    logic [`EXE_DATA_W-1:0]            ram_rdata;

    exe_stage u_exe_stage (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_bus         (in_bus),
        .in_allowin     (in_allowin),
        .ms_allowin     (ms_allowin),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus),
        .div_start      (div_start),
        .div_signed     (div_signed),
        .div_dividend   (div_dividend),
        .div_divisor    (div_divisor),
        .div_complete   (div_complete),
        .div_quotient   (div_quotient),
        .div_remainder  (div_remainder),
        .ram_en         (ram_en),
        .ram_we         (ram_we),
        .ram_addr       (ram_addr),
        .ram_wdata      (ram_wdata)
    );

    divider u_divider (
        .clk       (clk),
        .reset     (reset),
        .start     (div_start),
        .signed_op (div_signed),
        .dividend  (div_dividend),
        .divisor   (div_divisor),
        .complete  (div_complete),
        .quotient  (div_quotient),
        .remainder (div_remainder)
    );

    data_ram u_data_ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    mem_stage u_mem_stage (
        .clk            (clk),
        .reset          (reset),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus),
        .ms_allowin     (ms_allowin),
        .ram_rdata      (ram_rdata),
        .wb_valid       (wb_valid),
        .wb_bus         (wb_bus),
        .wb_ready       (wb_ready)
    );

endmodule

// File: tb/exe_tb.sv
`timescale 1ns/1ps
`include "exe_settings.svh"

module exe_tb;

    localparam int cols     = 15;
    localparam int max_recs = 64;
    localparam int half     = 20;
    localparam int dw       = `EXE_DATA_W;

    logic                   clk;
    logic                   reset;
    logic                   in_valid;
    exe_bus_pkg::ds_to_es_t in_bus;
    logic                   in_allowin;
    logic                   wb_valid;
    exe_bus_pkg::wb_t       wb_bus;
    logic                   wb_ready;

    logic [dw-1:0]          words [0:max_recs*cols-1];
    exe_bus_pkg::ds_to_es_t stim [0:max_recs-1];
    logic [dw-1:0]          exp_result [0:max_recs-1];
    exe_ops_pkg::excp_t     exp_excp [0:max_recs-1];
    int                     n_recs;
    int                     n_seen;
    int                     result_errs;
    int                     excp_errs;
    int                     other_errs;
    logic [dw-1:0]          last_lo;
    logic [dw-1:0]          last_hi;
    logic                   have_lo;
    logic                   have_hi;

    exe_top uut (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_bus     (in_bus),
        .in_allowin (in_allowin),
        .wb_valid   (wb_valid),
        .wb_bus     (wb_bus),
        .wb_ready   (wb_ready)
    );

    initial begin
        clk = 1'b0;
        forever #half clk = ~clk;
    end

    task automatic load_records();
        int b;
        for (int i = 0; i < max_recs*cols; i++) begin
            words[i] = '0;
        end
        $readmemh("tb/exe_testdata.txt", words);
        n_recs = 0;
        // a zero pc marks the end of the data
        while (n_recs < max_recs && words[n_recs*cols] != '0) begin
            b = n_recs * cols;
            stim[n_recs].pc          = words[b];
            stim[n_recs].rj_value    = words[b+1];
            stim[n_recs].rkd_value   = words[b+2];
            stim[n_recs].imm         = words[b+3];
            stim[n_recs].src1_is_pc  = words[b+4][2];
            stim[n_recs].src2_is_imm = words[b+4][1];
            stim[n_recs].src2_is_4   = words[b+4][0];
            stim[n_recs].alu_op      = exe_ops_pkg::alu_op_t'(words[b+5][3:0]);
            stim[n_recs].mem_op      = exe_ops_pkg::mem_op_t'(words[b+6][3:0]);
            stim[n_recs].div_op      = exe_ops_pkg::div_op_t'(words[b+7][1:0]);
            stim[n_recs].div_signed  = words[b+8][0];
            stim[n_recs].res_src     = exe_ops_pkg::res_src_t'(words[b+9][2:0]);
            stim[n_recs].dest        = words[b+10][4:0];
            stim[n_recs].gr_we       = words[b+11][0];
            stim[n_recs].ds_excp     = exe_ops_pkg::excp_t'(words[b+12][1:0]);
            exp_result[n_recs]       = words[b+13];
            exp_excp[n_recs]         = exe_ops_pkg::excp_t'(words[b+14][1:0]);
            n_recs++;
        end
    endtask

    task automatic check_result(input string name, input exe_bus_pkg::wb_t exp,
                                input exe_bus_pkg::wb_t act, input bit value_known);
        if (act.pc !== exp.pc) begin
            $display("ERR %s pc: expected %h, got %h", name, exp.pc, act.pc);
            result_errs++;
        end
        if (act.dest !== exp.dest) begin
            $display("ERR %s dest: expected %h, got %h", name, exp.dest, act.dest);
            result_errs++;
        end
        if (act.gr_we !== exp.gr_we) begin
            $display("ERR %s gr_we: expected %b, got %b", name, exp.gr_we, act.gr_we);
            result_errs++;
        end
        if (value_known && act.result !== exp.result) begin
            $display("ERR %s result: expected %h, got %h", name, exp.result, act.result);
            result_errs++;
        end
    endtask

    task automatic check_excp(input string name, input exe_ops_pkg::excp_t exp,
                              input exe_ops_pkg::excp_t act);
        if (act !== exp) begin
            $display("ERR %s excp: expected %s, got %s", name, exp.name(), act.name());
            excp_errs++;
        end
    endtask

    // low word must rise between reads, high word must not fall
    task automatic check_counter(input string name, input logic [dw-1:0] prev,
                                 input logic [dw-1:0] now, input bit strict);
        if (strict ? (now <= prev) : (now < prev)) begin
            $display("ERR %s counter: expected %s %h, got %h", name,
                     strict ? "above" : "at least", prev, now);
            other_errs++;
        end
    endtask

    task automatic finish_run();
        $display("errors: result %0d, exception %0d, other %0d",
                 result_errs, excp_errs, other_errs);
        if (result_errs + excp_errs + other_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    task automatic drive_records();
        int idle;
        for (int i = 0; i < n_recs; i++) begin
            idle = $urandom_range(3, 0);
            repeat (idle) @(negedge clk);
            in_bus   = stim[i];
            in_valid = 1'b1;
            // hold until a rising edge sees in_allowin
            @(posedge clk);
            while (!in_allowin) begin
                @(posedge clk);
            end
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    task automatic throttle_writeback();
        forever begin
            @(negedge clk);
            wb_ready = ($urandom_range(3, 0) != 0);
        end
    endtask

    task automatic watch_writeback();
        exe_bus_pkg::wb_t      expect_wb;
        exe_ops_pkg::res_src_t src;
        string                 name;
        bit                    known;
        forever begin
            @(posedge clk);
            if (wb_valid && wb_ready) begin
                if (n_seen >= n_recs) begin
                    $display("an extra writeback record arrived after all %0d instructions",
                             n_recs);
                    other_errs++;
                end else begin
                    name             = $sformatf("record %0d", n_seen);
                    src              = stim[n_seen].res_src;
                    expect_wb.pc     = stim[n_seen].pc;
                    expect_wb.dest   = stim[n_seen].dest;
                    expect_wb.gr_we  = stim[n_seen].gr_we &&
                                       exp_excp[n_seen] == exe_ops_pkg::excp_none;
                    expect_wb.result = exp_result[n_seen];
                    expect_wb.excp   = exp_excp[n_seen];
                    // faulting instructions and counter reads have no fixed value
                    known = exp_excp[n_seen] == exe_ops_pkg::excp_none &&
                            src != exe_ops_pkg::res_cnt_lo && src != exe_ops_pkg::res_cnt_hi;
                    check_result(name, expect_wb, wb_bus, known);
                    check_excp(name, exp_excp[n_seen], wb_bus.excp);
                    if (src == exe_ops_pkg::res_cnt_lo) begin
                        if (have_lo) begin
                            check_counter(name, last_lo, wb_bus.result, 1'b1);
                        end
                        last_lo = wb_bus.result;
                        have_lo = 1'b1;
                    end
                    if (src == exe_ops_pkg::res_cnt_hi) begin
                        if (have_hi) begin
                            check_counter(name, last_hi, wb_bus.result, 1'b0);
                        end
                        last_hi = wb_bus.result;
                        have_hi = 1'b1;
                    end
                    n_seen++;
                end
            end
        end
    endtask

    task automatic watchdog();
        repeat ((n_recs + 1) * 60) @(posedge clk);
        $display("timeout: only %0d of %0d records came back within %0d cycles",
                 n_seen, n_recs, (n_recs + 1) * 60);
        other_errs++;
        finish_run();
    endtask

    initial begin
        void'($urandom(77));
        reset       = 1'b1;
        in_valid    = 1'b0;
        in_bus      = '0;
        wb_ready    = 1'b0;
        n_seen      = 0;
        result_errs = 0;
        excp_errs   = 0;
        other_errs  = 0;
        have_lo     = 1'b0;
        have_hi     = 1'b0;
        last_lo     = '0;
        last_hi     = '0;
        load_records();
        if (n_recs == 0) begin
            $display("no records could be read from tb/exe_testdata.txt");
            other_errs++;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        fork
            throttle_writeback();
            watch_writeback();
            watchdog();
        join_none
        drive_records();
        wait (n_seen == n_recs);
        // a few more cycles to catch a duplicated record
        repeat (8) @(posedge clk);
        finish_run();
    end

endmodule

// File: tb/exe_testdata.txt
// pc rj rkd imm src alu mem div sgn res dest we ds_excp exp_result exp_excp
// src bits: 4 = src1 from pc, 2 = src2 from imm, 1 = src2 is 4; counter reads ignore exp_result
1c000000 00000005 00000007 00000000 0 0 0 0 0 0 01 1 0 0000000c 0
1c000004 00000003 00000005 00000000 0 1 0 0 0 0 02 1 0 fffffffe 0
1c000008 ffffffff 00000001 00000000 0 2 0 0 0 0 03 1 0 00000001 0
1c00000c ffffffff 00000001 00000000 0 3 0 0 0 0 04 1 0 00000000 0
1c000010 f0f0f0f0 12345678 0ff00ff0 2 4 0 0 0 0 05 1 0 00f000f0 0
1c000014 0f0f0000 00000f0f 00000000 0 7 0 0 0 0 06 1 0 f0f0f0f0 0
1c000018 00000001 ffffffff 00000024 2 8 0 0 0 0 07 1 0 00000010 0
1c00001c 80000000 00000004 00000000 0 a 0 0 0 0 08 1 0 f8000000 0
1c000020 ffffffff 00000000 12345000 2 b 0 0 0 0 09 1 0 12345000 0
1c000024 11111111 00000000 00000000 5 0 0 0 0 0 0a 1 0 1c000028 0
1c000028 11111111 00000000 00001000 6 0 0 0 0 0 0b 1 0 1c001028 0
1c00002c 00000100 11223344 00000000 2 0 8 0 0 0 00 0 0 00000100 0
1c000030 00000100 000000aa 00000001 2 0 6 0 0 0 00 0 0 00000101 0
1c000034 00000100 ffff8001 00000002 2 0 7 0 0 0 00 0 0 00000102 0
1c000038 000000f0 00000000 00000010 2 0 3 0 0 2 0c 1 0 8001aa44 0
1c00003c 00000100 00000000 00000001 2 0 1 0 0 2 0d 1 0 ffffffaa 0
1c000040 00000100 00000000 00000001 2 0 4 0 0 2 0e 1 0 000000aa 0
1c000044 00000100 00000000 00000002 2 0 2 0 0 2 0f 1 0 ffff8001 0
1c000048 00000100 00000000 00000002 2 0 5 0 0 2 10 1 0 00008001 0
1c00004c 00000100 deadbeef 00000002 2 0 8 0 0 0 00 0 0 00000102 2
1c000050 00000100 00000000 00000003 2 0 2 0 0 2 11 1 0 00000000 2
1c000054 00000100 00000000 00000000 2 0 3 0 0 2 12 1 0 8001aa44 0
1c000058 00000100 00000000 00000001 2 0 3 0 0 2 13 1 1 00000000 1
1c00005c fffffff9 00000002 00000000 0 0 0 1 1 1 14 1 0 fffffffd 0
1c000060 fffffff9 00000002 00000000 0 0 0 2 1 1 15 1 0 ffffffff 0
1c000064 fffffff9 00000002 00000000 0 0 0 1 0 1 16 1 0 7ffffffc 0
1c000068 fffffff9 00000002 00000000 0 0 0 2 0 1 17 1 0 00000001 0
1c00006c 00000007 fffffffe 00000000 0 0 0 1 1 1 18 1 0 fffffffd 0
1c000070 00000011 00000000 00000000 0 0 0 1 1 1 19 1 0 ffffffff 0
1c000074 fffffff9 00000000 00000000 0 0 0 2 1 1 1a 1 0 fffffff9 0
1c000078 00000001 00000001 00000000 0 0 0 0 0 0 1b 1 0 00000002 0
1c00007c 00000000 00000000 00000000 0 0 0 0 0 3 1c 1 0 00000000 0
1c000080 00000000 00000000 00000000 0 0 0 0 0 4 1d 1 0 00000000 0
1c000084 00000000 00000000 00000000 0 0 0 0 0 3 1e 1 0 00000000 0
1c000088 00000000 00000000 00000000 0 0 0 0 0 4 1f 1 0 00000000 0

// File: compile.f
+incdir+common
common/exe_ops_pkg.sv
common/exe_bus_pkg.sv
exe/alu.sv
exe/exe_stage.sv
hdl/divider.sv
hdl/mem_stage.sv
hdl/data_ram.sv
hdl/exe_top.sv
tb/exe_tb.sv

// File: Makefile
TOP = exe_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
